// ==== flist.f ====
source/net_stream_pkg.sv
source/ccross_cfg_pkg.sv
source/reset_sync.sv
source/axis_reg_chain.sv
source/async_stream_fifo.sv
source/net_ccross_early.sv
sim/tb_net_ccross.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the crossing testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_net_ccross -f flist.f -o tb_net_ccross \
  > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_net_ccross > sim.log 2>&1
cat sim.log

grep -qx "Verification passed" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see sim.log"; exit 1; }

// ==== sim/tb_net_ccross.sv ====
// testbench for the early network crossing with random streams both ways against a queue model
`default_nettype none

module tb_net_ccross;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int rdy_low  = 0;  // ready held low
  localparam int rdy_high = 1;  // ready held high
  localparam int rdy_rand = 2;  // ready toggles at random

  logic nclk = 1'b0;
  logic rclk = 1'b0;
  logic arst_n;
  logic rarst_n;

  net_stream_pkg::net_beat_t rx_r_beat;
  logic                      rx_r_valid;
  logic                      rx_r_ready;
  net_stream_pkg::net_beat_t rx_n_beat;
  logic                      rx_n_valid;
  logic                      rx_n_ready;
  net_stream_pkg::net_beat_t tx_n_beat;
  logic                      tx_n_valid;
  logic                      tx_n_ready;
  net_stream_pkg::net_beat_t tx_r_beat;
  logic                      tx_r_valid;
  logic                      tx_r_ready;

  // source queues and in-order model
  net_stream_pkg::net_beat_t rx_send_q[$];
  net_stream_pkg::net_beat_t rx_exp_q[$];
  net_stream_pkg::net_beat_t tx_send_q[$];
  net_stream_pkg::net_beat_t tx_exp_q[$];

  int unsigned rx_sent = 0;
  int unsigned rx_got  = 0;
  int unsigned tx_sent = 0;
  int unsigned tx_got  = 0;
  int unsigned errors  = 0;
  int unsigned checks  = 0;
  int unsigned tests_run = 0;
  bit          hung    = 1'b0;  // a wait ran out
  int          rx_rdy_mode = rdy_high;
  int          tx_rdy_mode = rdy_high;

  net_ccross_early #(
    .reg_stages     (ccross_cfg_pkg::def_reg_stages),
    .fifo_depth_log2(ccross_cfg_pkg::def_fifo_depth_log2),
    .sync_stages    (ccross_cfg_pkg::def_sync_stages),
    .cross_enabled  (1'b1)
  ) net_ccross_early_i (
    .nclk(nclk), .arst_n(arst_n), .rclk(rclk), .rarst_n(rarst_n),
    .rx_r_beat(rx_r_beat), .rx_r_valid(rx_r_valid), .rx_r_ready(rx_r_ready),
    .rx_n_beat(rx_n_beat), .rx_n_valid(rx_n_valid), .rx_n_ready(rx_n_ready),
    .tx_n_beat(tx_n_beat), .tx_n_valid(tx_n_valid), .tx_n_ready(tx_n_ready),
    .tx_r_beat(tx_r_beat), .tx_r_valid(tx_r_valid), .tx_r_ready(tx_r_ready)
  );

  always #2.0 nclk = ~nclk;  // 4 ns
  always #1.5 rclk = ~rclk;  // 3 ns period standing in for the 322 MHz side

  // --------------------------------------------------------------------------
  // model and compare helpers
  // --------------------------------------------------------------------------

  function automatic net_stream_pkg::net_beat_t random_beat();
    net_stream_pkg::net_beat_t b;
    for (int k = 0; k < int'(net_stream_pkg::net_data_bits / 32); k++) begin
      b.data[k*32 +: 32] = $urandom();
    end
    b.keep = {$urandom(), $urandom()};  // 64 byte enables
    b.last = 1'($urandom());
    return b;
  endfunction

  // crossing keeps order, so the expected beat is the oldest one sent
  function automatic net_stream_pkg::net_beat_t next_expected(input bit tx_side);
    if (tx_side) begin
      return tx_exp_q.pop_front();
    end
    return rx_exp_q.pop_front();
  endfunction

  task automatic check_beat(input string name, input net_stream_pkg::net_beat_t exp,
                            input net_stream_pkg::net_beat_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0.3f ns: %s expected %h, got %h", $realtime, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int unsigned exp,
                             input int unsigned act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("Fail at %0.3f ns: %s expected %0d, got %0d", $realtime, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0.3f ns: %s expected %b, got %b", $realtime, name, exp, act);
    end
  endtask

  task automatic queue_beats(input int unsigned n, input bit do_rx, input bit do_tx);
    net_stream_pkg::net_beat_t b;
    for (int unsigned k = 0; k < n; k++) begin
      if (do_rx) begin
        b = random_beat();
        rx_send_q.push_back(b);
        rx_exp_q.push_back(b);
        rx_sent++;
      end
      if (do_tx) begin
        b = random_beat();
        tx_send_q.push_back(b);
        tx_exp_q.push_back(b);
        tx_sent++;
      end
    end
  endtask

  task automatic wait_delivery(input int unsigned limit, input string what);
    int unsigned n;
    n = 0;
    while ((rx_got != rx_sent || tx_got != tx_sent) && n < limit) begin
      @(posedge nclk);
      n++;
    end
    if (rx_got != rx_sent || tx_got != tx_sent) begin
      $display("timeout in %s after %0d cycles: rx %0d of %0d beats, tx %0d of %0d beats",
               what, limit, rx_got, rx_sent, tx_got, tx_sent);
      hung = 1'b1;
    end
  endtask

  task automatic wait_release(input int unsigned limit);
    int unsigned n;
    n = 0;
    while (!(rx_r_ready && tx_n_ready) && n < limit) begin
      @(posedge nclk);
      n++;
    end
    if (!(rx_r_ready && tx_n_ready)) begin
      $display("input ready never rose within %0d cycles after reset", limit);
      hung = 1'b1;
    end
  endtask

  task automatic wait_rx_stall(input int unsigned limit);
    int unsigned n;
    n = 0;
    while (rx_r_ready && n < limit) begin
      @(posedge rclk);
      n++;
    end
    if (rx_r_ready) begin
      $display("rx input ready stayed high for %0d cycles with the output stalled", limit);
      hung = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int unsigned err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  // --------------------------------------------------------------------------
  // drivers and monitors
  // --------------------------------------------------------------------------

  // next beat goes out once the last one is taken
  always @(posedge rclk) begin
    if (!rx_r_valid || rx_r_ready) begin
      if (rx_send_q.size() > 0) begin
        rx_r_beat  <= rx_send_q.pop_front();
        rx_r_valid <= 1'b1;
      end else begin
        rx_r_valid <= 1'b0;
      end
    end
  end

  always @(posedge nclk) begin
    if (!tx_n_valid || tx_n_ready) begin
      if (tx_send_q.size() > 0) begin
        tx_n_beat  <= tx_send_q.pop_front();
        tx_n_valid <= 1'b1;
      end else begin
        tx_n_valid <= 1'b0;
      end
    end
  end

  always @(posedge nclk) begin
    case (rx_rdy_mode)
      rdy_low:  rx_n_ready <= 1'b0;
      rdy_high: rx_n_ready <= 1'b1;
      default:  rx_n_ready <= 1'($urandom());
    endcase
  end

  always @(posedge rclk) begin
    case (tx_rdy_mode)
      rdy_low:  tx_r_ready <= 1'b0;
      rdy_high: tx_r_ready <= 1'b1;
      default:  tx_r_ready <= 1'($urandom());
    endcase
  end

  always @(posedge nclk) begin  // rx output in the nclk domain
    if (rx_n_valid && rx_n_ready) begin
      if (rx_exp_q.size() == 0) begin
        errors++;
        $display("rx_n delivered a beat at %0.3f ns with none outstanding", $realtime);
      end else begin
        check_beat("rx_n_beat", next_expected(1'b0), rx_n_beat);
      end
      rx_got++;
    end
  end

  always @(posedge rclk) begin  // tx output in the rclk domain
    if (tx_r_valid && tx_r_ready) begin
      if (tx_exp_q.size() == 0) begin
        errors++;
        $display("tx_r delivered a beat at %0.3f ns with none outstanding", $realtime);
      end else begin
        check_beat("tx_r_beat", next_expected(1'b1), tx_r_beat);
      end
      tx_got++;
    end
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  task automatic run_tests();
    int unsigned e0;
    e0 = errors;
    repeat (5) @(posedge nclk);
    check_bit("rx_r_ready", 1'b0, rx_r_ready);  // still in reset
    check_bit("tx_n_ready", 1'b0, tx_n_ready);
    repeat (5) @(posedge nclk);
    arst_n  <= 1'b1;
    rarst_n <= 1'b1;
    wait_release(100);
    if (hung) return;
    check_bit("rx_n_valid", 1'b0, rx_n_valid);
    check_bit("tx_r_valid", 1'b0, tx_r_valid);
    repeat (40) @(posedge nclk);  // nothing may appear in this idle window
    check_count("rx beats without input", 0, rx_got);
    check_count("tx beats without input", 0, tx_got);
    report_test("reset and idle", e0);

    e0 = errors;
    queue_beats(200, 1'b1, 1'b0);
    wait_delivery(2000, "rx stream");
    if (hung) return;
    repeat (20) @(posedge nclk);  // late or repeated beats would land here
    check_count("rx beats", rx_sent, rx_got);
    report_test("rx stream", e0);

    e0 = errors;
    queue_beats(200, 1'b0, 1'b1);
    wait_delivery(2000, "tx stream");
    if (hung) return;
    repeat (20) @(posedge nclk);
    check_count("tx beats", tx_sent, tx_got);
    report_test("tx stream", e0);

    e0 = errors;
    rx_rdy_mode = rdy_rand;
    tx_rdy_mode = rdy_rand;
    queue_beats(200, 1'b1, 1'b1);
    wait_delivery(6000, "both ways with random ready");
    if (hung) return;
    repeat (20) @(posedge nclk);
    check_count("rx beats", rx_sent, rx_got);
    check_count("tx beats", tx_sent, tx_got);
    report_test("both ways, random ready", e0);

    e0 = errors;
    rx_rdy_mode = rdy_low;
    tx_rdy_mode = rdy_high;
    repeat (2) @(posedge nclk);  // let ready settle low
    queue_beats(64, 1'b1, 1'b0);  // more than chains and fifo hold
    wait_rx_stall(1000);
    if (hung) return;
    repeat (20) @(posedge nclk);
    check_bit("rx_r_ready", 1'b0, rx_r_ready);  // input stays closed while full
    rx_rdy_mode = rdy_high;
    wait_delivery(2000, "drain after stall");
    if (hung) return;
    repeat (20) @(posedge nclk);
    check_count("rx beats after drain", rx_sent, rx_got);
    check_count("rx beats outstanding", 0, rx_exp_q.size());
    report_test("back-pressure and drain", e0);
  endtask

  initial begin : main
    void'($urandom(32'h8ab32bde));
    arst_n     <= 1'b0;
    rarst_n    <= 1'b0;
    rx_r_beat  <= '0;
    rx_r_valid <= 1'b0;
    rx_n_ready <= 1'b1;
    tx_n_beat  <= '0;
    tx_n_valid <= 1'b0;
    tx_r_ready <= 1'b1;
    run_tests();
    $display("%0d tests, %0d checks, %0d errors%s", tests_run, checks, errors,
             hung ? ", stopped on timeout" : "");
    if (errors == 0 && !hung) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_net_ccross

`default_nettype wire

// ==== source/net_ccross_early.sv ====
// early network clock crossing, rx rclk to nclk and tx nclk to rclk
`default_nettype none

module net_ccross_early #(
  parameter int unsigned reg_stages      = ccross_cfg_pkg::def_reg_stages,
  parameter int unsigned fifo_depth_log2 = ccross_cfg_pkg::def_fifo_depth_log2,
  parameter int unsigned sync_stages     = ccross_cfg_pkg::def_sync_stages,
  parameter bit          cross_enabled   = 1'b1  // 0 only when rclk is nclk
) (
  input  wire                       nclk,       // internal clock
  input  wire                       arst_n,
  input  wire                       rclk,       // raw network clock, ~322 MHz
  input  wire                       rarst_n,
  // rx in, rclk
  input  wire net_stream_pkg::net_beat_t rx_r_beat,
  input  wire                       rx_r_valid,
  output logic                      rx_r_ready,
  // rx out, nclk
  output net_stream_pkg::net_beat_t rx_n_beat,
  output logic                      rx_n_valid,
  input  wire                       rx_n_ready,
  // tx in, nclk
  input  wire net_stream_pkg::net_beat_t tx_n_beat,
  input  wire                       tx_n_valid,
  output logic                      tx_n_ready,
  // tx out, rclk
  output net_stream_pkg::net_beat_t tx_r_beat,
  output logic                      tx_r_valid,
  input  wire                       tx_r_ready
);

  logic n_rst_n;  // nclk domain
  logic r_rst_n;  // rclk domain

  reset_sync #(.sync_stages(sync_stages)) n_rst_sync_i (
    .clk(nclk), .arst_n(arst_n), .rst_n(n_rst_n)
  );
  reset_sync #(.sync_stages(sync_stages)) r_rst_sync_i (
    .clk(rclk), .arst_n(rarst_n), .rst_n(r_rst_n)
  );

  // internal links, chain side and fifo side
  net_stream_pkg::net_beat_t rx_r2f_beat, rx_f2n_beat, tx_n2f_beat, tx_f2r_beat;
  logic rx_r2f_valid, rx_r2f_ready, rx_f2n_valid, rx_f2n_ready;
  logic tx_n2f_valid, tx_n2f_ready, tx_f2r_valid, tx_f2r_ready;

  // --------------------------------------------------------------------------
  // register chains
  // --------------------------------------------------------------------------

  axis_reg_chain #(.reg_stages(reg_stages)) rx_r_chain_i (  // rx, rclk side
    .clk(rclk), .rst_n(r_rst_n),
    .s_beat(rx_r_beat), .s_valid(rx_r_valid), .s_ready(rx_r_ready),
    .m_beat(rx_r2f_beat), .m_valid(rx_r2f_valid), .m_ready(rx_r2f_ready)
  );
  axis_reg_chain #(.reg_stages(reg_stages)) rx_n_chain_i (  // rx, nclk side
    .clk(nclk), .rst_n(n_rst_n),
    .s_beat(rx_f2n_beat), .s_valid(rx_f2n_valid), .s_ready(rx_f2n_ready),
    .m_beat(rx_n_beat), .m_valid(rx_n_valid), .m_ready(rx_n_ready)
  );
  axis_reg_chain #(.reg_stages(reg_stages)) tx_n_chain_i (  // tx, nclk side
    .clk(nclk), .rst_n(n_rst_n),
    .s_beat(tx_n_beat), .s_valid(tx_n_valid), .s_ready(tx_n_ready),
    .m_beat(tx_n2f_beat), .m_valid(tx_n2f_valid), .m_ready(tx_n2f_ready)
  );
  axis_reg_chain #(.reg_stages(reg_stages)) tx_r_chain_i (  // tx, rclk side
    .clk(rclk), .rst_n(r_rst_n),
    .s_beat(tx_f2r_beat), .s_valid(tx_f2r_valid), .s_ready(tx_f2r_ready),
    .m_beat(tx_r_beat), .m_valid(tx_r_valid), .m_ready(tx_r_ready)
  );

  // --------------------------------------------------------------------------
  // crossings
  // --------------------------------------------------------------------------

  if (cross_enabled) begin : g_cross
    async_stream_fifo #(.fifo_depth_log2(fifo_depth_log2), .sync_stages(sync_stages))
      rx_fifo_i (
        .wclk(rclk), .wrst_n(r_rst_n),
        .w_beat(rx_r2f_beat), .w_valid(rx_r2f_valid), .w_ready(rx_r2f_ready),
        .rclk(nclk), .rrst_n(n_rst_n),
        .r_beat(rx_f2n_beat), .r_valid(rx_f2n_valid), .r_ready(rx_f2n_ready)
      );
    async_stream_fifo #(.fifo_depth_log2(fifo_depth_log2), .sync_stages(sync_stages))
      tx_fifo_i (
        .wclk(nclk), .wrst_n(n_rst_n),
        .w_beat(tx_n2f_beat), .w_valid(tx_n2f_valid), .w_ready(tx_n2f_ready),
        .rclk(rclk), .rrst_n(r_rst_n),
        .r_beat(tx_f2r_beat), .r_valid(tx_f2r_valid), .r_ready(tx_f2r_ready)
      );
  end else begin : g_direct
    // same clock on both sides, chains meet back to back
    assign rx_f2n_beat  = rx_r2f_beat;
    assign rx_f2n_valid = rx_r2f_valid;
    assign rx_r2f_ready = rx_f2n_ready;
    assign tx_f2r_beat  = tx_n2f_beat;
    assign tx_f2r_valid = tx_n2f_valid;
    assign tx_n2f_ready = tx_f2r_ready;
  end

endmodule : net_ccross_early

`default_nettype wire

// ==== source/async_stream_fifo.sv ====
// dual-clock fifo of stream beats with gray pointers and a registered read port
`default_nettype none

module async_stream_fifo #(
  parameter int unsigned fifo_depth_log2 = ccross_cfg_pkg::def_fifo_depth_log2,
  parameter int unsigned sync_stages     = ccross_cfg_pkg::def_sync_stages
) (
  // write side
  input  wire                       wclk,
  input  wire                       wrst_n,
  input  wire net_stream_pkg::net_beat_t w_beat,
  input  wire                       w_valid,
  output logic                      w_ready,
  // read side
  input  wire                       rclk,
  input  wire                       rrst_n,
  output net_stream_pkg::net_beat_t r_beat,
  output logic                      r_valid,
  input  wire                       r_ready
);

  localparam int unsigned aw    = fifo_depth_log2;  // address bits
  localparam int unsigned depth = 1 << aw;

  // storage of one word per beat
  logic [net_stream_pkg::net_beat_bits-1:0] mem [depth];

  // read pointer, binary for addressing and gray for the crossing
  logic [aw:0] rbin_q;
  logic [aw:0] rgray_q;

  function automatic logic [aw:0] bin2gray(input logic [aw:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [aw:0] gray2bin(input logic [aw:0] g);
    logic [aw:0] b;
    b[aw] = g[aw];
    for (int k = int'(aw) - 1; k >= 0; k--) begin
      b[k] = b[k+1] ^ g[k];
    end
    return b;
  endfunction

  // --------------------------------------------------------------------------
  // write domain
  // --------------------------------------------------------------------------

  logic [aw:0] wbin_q;
  logic [aw:0] wgray_q;
  logic [aw:0] wbin_nxt;
  logic [aw:0] wgray_nxt;
  logic [aw:0] rq_sync [sync_stages];  // read gray into wclk
  logic [aw:0] rq_gray;
  logic        full_q;
  logic        do_write;

  assign do_write  = w_valid && w_ready;
  assign wbin_nxt  = wbin_q + (aw+1)'(do_write);
  assign wgray_nxt = bin2gray(wbin_nxt);
  assign rq_gray   = rq_sync[sync_stages-1];
  assign w_ready   = !full_q;

  always_ff @(posedge wclk or negedge wrst_n) begin
    if (!wrst_n) begin
      wbin_q  <= '0;
      wgray_q <= '0;
      full_q  <= 1'b1;  // hold ready low in reset
    end else begin
      wbin_q  <= wbin_nxt;
      wgray_q <= wgray_nxt;
      // full when the top two bits are inverted and the rest equal
      full_q  <= wgray_nxt == {~rq_gray[aw:aw-1], rq_gray[aw-2:0]};
    end
  end

  always_ff @(posedge wclk or negedge wrst_n) begin
    if (!wrst_n) begin
      for (int k = 0; k < int'(sync_stages); k++) begin
        rq_sync[k] <= '0;
      end
    end else begin
      rq_sync[0] <= rgray_q;
      for (int k = 1; k < int'(sync_stages); k++) begin
        rq_sync[k] <= rq_sync[k-1];
      end
    end
  end

  always_ff @(posedge wclk) begin
    if (do_write) begin
      mem[wbin_q[aw-1:0]] <= w_beat;
    end
  end

  // --------------------------------------------------------------------------
  // read domain
  // --------------------------------------------------------------------------

  logic [aw:0] wq_sync [sync_stages];  // write gray into rclk
  logic [aw:0] wq_gray;
  logic        empty;
  logic        fetch;
  logic        r_valid_q;
  net_stream_pkg::net_beat_t r_beat_q;

  assign wq_gray = wq_sync[sync_stages-1];
  assign empty   = rgray_q == wq_gray;
  assign fetch   = !empty && (!r_valid_q || r_ready);  // output slot free

  always_ff @(posedge rclk or negedge rrst_n) begin
    if (!rrst_n) begin
      for (int k = 0; k < int'(sync_stages); k++) begin
        wq_sync[k] <= '0;
      end
    end else begin
      wq_sync[0] <= wgray_q;
      for (int k = 1; k < int'(sync_stages); k++) begin
        wq_sync[k] <= wq_sync[k-1];
      end
    end
  end

  always_ff @(posedge rclk or negedge rrst_n) begin
    if (!rrst_n) begin
      rbin_q    <= '0;
      rgray_q   <= '0;
      r_valid_q <= 1'b0;
    end else if (fetch) begin
      rbin_q    <= rbin_q + 1'b1;
      rgray_q   <= bin2gray(rbin_q + 1'b1);  // glitch-free copy for wclk
      r_valid_q <= 1'b1;
    end else if (r_ready) begin
      r_valid_q <= 1'b0;  // consumed with nothing behind it
    end
  end

  always_ff @(posedge rclk) begin
    if (fetch) begin
      r_beat_q <= mem[rbin_q[aw-1:0]];
    end
  end

  assign r_beat  = r_beat_q;
  assign r_valid = r_valid_q;

  // writer never gets more than depth ahead of what it has seen read
  a_no_overflow : assert property (
    @(posedge wclk) disable iff (!wrst_n)
    (aw+1)'(wbin_q - gray2bin(rq_gray)) <= (aw+1)'(depth)
  ) else $error("write into full fifo");

  // reader never passes the write pointer it has seen
  a_no_underflow : assert property (
    @(posedge rclk) disable iff (!rrst_n)
    (aw+1)'(gray2bin(wq_gray) - rbin_q) <= (aw+1)'(depth)
  ) else $error("read from empty fifo");

endmodule : async_stream_fifo

`default_nettype wire

// ==== source/axis_reg_chain.sv ====
// chain of skid register stages, registered ready at full throughput
`default_nettype none

module axis_reg_chain #(
  parameter int unsigned reg_stages = ccross_cfg_pkg::def_reg_stages
) (
  input  wire                       clk,
  input  wire                       rst_n,
  // upstream side
  input  wire net_stream_pkg::net_beat_t s_beat,
  input  wire                       s_valid,
  output logic                      s_ready,
  // downstream side
  output net_stream_pkg::net_beat_t m_beat,
  output logic                      m_valid,
  input  wire                       m_ready
);

  // link i feeds stage i, stage i drives link i+1
  wire net_stream_pkg::net_beat_t stg_beat [reg_stages+1];
  wire [reg_stages:0]             stg_valid;
  wire [reg_stages:0]             stg_ready;

  assign stg_beat[0]  = s_beat;
  assign stg_valid[0] = s_valid;
  assign s_ready      = stg_ready[0];

  // --------------------------------------------------------------------------
  // skid stages
  // --------------------------------------------------------------------------

  for (genvar i = 0; i < reg_stages; i++) begin : g_stage
    net_stream_pkg::net_beat_t main_q;  // output register
    net_stream_pkg::net_beat_t skid_q;  // overflow slot
    logic main_vld;
    logic skid_vld;
    logic in_rdy;                       // registered ready upstream
    logic main_free;
    logic take_in;
    logic main_vld_nxt;
    logic skid_vld_nxt;

    assign main_free = !main_vld || stg_ready[i+1];  // main empties this edge
    assign take_in   = stg_valid[i] && in_rdy;       // implies skid empty

    always_comb begin
      main_vld_nxt = main_vld;
      skid_vld_nxt = skid_vld;
      if (main_free) begin
        main_vld_nxt = skid_vld || take_in;  // refill from skid first
        skid_vld_nxt = 1'b0;
      end else if (take_in) begin
        skid_vld_nxt = 1'b1;                 // stalled, park the beat
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        main_vld <= 1'b0;
        skid_vld <= 1'b0;
        in_rdy   <= 1'b0;  // low until reset is released
      end else begin
        main_vld <= main_vld_nxt;
        skid_vld <= skid_vld_nxt;
        in_rdy   <= !skid_vld_nxt;
      end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
      if (main_free) begin
        main_q <= skid_vld ? skid_q : stg_beat[i];
      end
      if (!main_free && take_in) begin
        skid_q <= stg_beat[i];
      end
    end

    assign stg_beat[i+1]  = main_q;
    assign stg_valid[i+1] = main_vld;
    assign stg_ready[i]   = in_rdy;
  end : g_stage

  assign m_beat                 = stg_beat[reg_stages];
  assign m_valid                = stg_valid[reg_stages];
  assign stg_ready[reg_stages]  = m_ready;

  // a stalled beat stays put through every stage up to the output
  a_hold_until_ready : assert property (
    @(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_beat)
  ) else $error("m_valid dropped or beat changed before m_ready");

endmodule : axis_reg_chain

`default_nettype wire

// ==== source/reset_sync.sv ====
// reset synchronizer, asserts at once and releases on the local clock
`default_nettype none

module reset_sync #(
  parameter int unsigned sync_stages = ccross_cfg_pkg::def_sync_stages
) (
  input  wire  clk,     // domain clock
  input  wire  arst_n,  // raw async reset, any clock
  output logic rst_n    // clean reset for the domain
);

  // shift register of ones, cleared by the raw reset
  logic [sync_stages-1:0] sync_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= '0;  // assert right away
    end else begin
      sync_q <= {sync_q[sync_stages-2:0], 1'b1};  // walk a one in
    end
  end

  // release after sync_stages edges
  assign rst_n = sync_q[sync_stages-1];

  // first flop may go metastable on release,
  // the rest of the chain settles it before the domain sees it

endmodule : reset_sync

`default_nettype wire

// ==== source/ccross_cfg_pkg.sv ====
// default build settings for the early network clock crossing
`default_nettype none

package ccross_cfg_pkg;

  // register stages per chain, one per side and direction
  localparam int unsigned def_reg_stages = 4;

  // fifo holds 2**n beats
  localparam int unsigned def_fifo_depth_log2 = 4;  // 16 beats

  // flops in each pointer and reset synchronizer
  localparam int unsigned def_sync_stages = 2;

  // 16 beats cover the pointer round trip at 322 MHz vs nclk
  // with some slack for the output register on the read side

endpackage : ccross_cfg_pkg

`default_nettype wire

// ==== source/net_stream_pkg.sv ====
// network stream beat layout shared by every stream port of the crossing
`default_nettype none

package net_stream_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------

  // 512-bit datapath from the mac side
  localparam int unsigned net_data_bits = 512;

  // one byte-enable per data byte
  localparam int unsigned net_keep_bits = net_data_bits / 8;

  // --------------------------------------------------------------------------
  // beat
  // --------------------------------------------------------------------------

  // one transfer on a stream link, msb first: data, keep, last
  typedef struct packed {
    logic [net_data_bits-1:0] data;  // payload
    logic [net_keep_bits-1:0] keep;  // valid bytes
    logic                     last;  // end of packet
  } net_beat_t;

  // flat width for storage that holds whole beats
  localparam int unsigned net_beat_bits = $bits(net_beat_t);

  // 512 + 64 + 1
  // keep is not checked against data anywhere in the crossing,
  // beats are moved as opaque words

endpackage : net_stream_pkg

`default_nettype wire
